// File: build.f
+incdir+.
ordr_pkg.sv
ordr_tag_store.sv
ordr_resp_match.sv
ordr_release.sv
ordr_top.sv
tb_clk_gen.sv
tb_ordr_top.sv

// File: Bender.yml
package:
  name: ordr

export_include_dirs:
  - .

sources:
  - ordr_pkg.sv
  - ordr_tag_store.sv
  - ordr_resp_match.sv
  - ordr_release.sv
  - ordr_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_ordr_top.sv

// File: tb_ordr_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ordr_config.svh"

module tb_ordr_top
  import ordr_pkg::*;
();

  localparam int MAX_CYCLES = 4000;

  logic                       clk;
  logic                       rst;
  logic                       i_req_valid;
  logic                       o_req_rdy;
  req_type_e                  i_req_type;
  logic [`ORDR_CH_W-1:0]      i_req_ch;
  logic [`ORDR_CH_W-1:0]      i_resp_ch;
  logic [`ORDR_BK_W-1:0]      i_req_bk;
  logic [`ORDR_BK_W-1:0]      i_resp_bk;
  logic [`ORDR_ROW_W-1:0]     i_req_row;
  logic [`ORDR_ROW_W-1:0]     i_resp_row;
  logic [`ORDR_COL_W-1:0]     i_req_col;
  logic [`ORDR_COL_W-1:0]     i_resp_col;
  logic                       i_resp_valid;
  logic [`ORDR_DATA_W-1:0]    i_resp_data;
  logic                       o_axi_valid;
  logic                       i_axi_rdy;
  logic [`ORDR_DATA_W-1:0]    o_axi_data;
  logic                       o_pgen_valid;
  logic                       i_pgen_rdy;
  logic [`ORDR_DATA_W-1:0]    o_pgen_data;
  rd_type_e                   o_pgen_rd_type;
  logic                       o_unmatched;

  // expected entries in issue order
  logic [`ORDR_ADDR_W-1:0]    exp_addr [$];
  rd_type_e                   exp_cls [$];
  logic [`ORDR_DATA_W-1:0]    exp_data [$];
  logic                       exp_has [$];

  req_type_e                  req_types [4] =
    '{REQ_READ, REQ_READ_SBK, REQ_READ_MAC, REQ_READ_AF};
  rd_type_e                   rd_classes [4] =
    '{DRAM_RD, DRAMSBK_RD, MACREG_RD, AFREG_RD};
  logic [`ORDR_ADDR_W-1:0]    addrs [`ORDR_DEPTH];
  int                         order [`ORDR_DEPTH];
  logic [31:0]                lfsr = 32'h82d8_28f5;
  logic                       resp_unm_exp;
  logic                       unm_stage;
  logic                       held_axi;
  logic                       held_pgen;
  logic [`ORDR_DATA_W-1:0]    held_data;
  int                         cycles = 0;

  tb_clk_gen u_clk_gen (.o_clk(clk), .o_rst(rst));

  ordr_top i_dut (.*);

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "bit mismatch");
    end
  endtask

  task automatic check_data(input string name, input logic [`ORDR_DATA_W-1:0] got,
                            input logic [`ORDR_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_rd_type(input string name, input rd_type_e got, input rd_type_e exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
      $display("Simulation FAILED");
      $fatal(1, "read type mismatch");
    end
  endtask

  task automatic report_error(input string what);
    $display("Error at %0t: %s", $time, what);
    $display("Simulation FAILED");
    $fatal(1, "testbench stopped");
  endtask

  // fibonacci lfsr x^32+x^22+x^2+x+1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // low column bits carry the index, so a batch never repeats an address
  function automatic logic [`ORDR_ADDR_W-1:0] random_addr(input int idx);
    logic [31:0]             r;
    logic [`ORDR_ADDR_W-1:0] a;
    r      = rand_bits(`ORDR_ADDR_W);
    a      = r[`ORDR_ADDR_W-1:0];
    a[3:0] = idx[3:0];
    return a;
  endfunction

  task automatic send_req(input req_type_e rtype, input rd_type_e cls,
                          input logic [`ORDR_ADDR_W-1:0] addr);
    logic took;
    i_req_valid = 1'b1;
    i_req_type  = rtype;
    {i_req_ch, i_req_bk, i_req_row, i_req_col} = addr;
    do begin
      @(negedge clk);
      took = o_req_rdy;
      @(posedge clk);
      #1;
    end while (!took);
    i_req_valid = 1'b0;
    exp_addr.push_back(addr);
    exp_cls.push_back(cls);
    exp_data.push_back('0);
    exp_has.push_back(1'b0);
  endtask

  // owner is the oldest entry with this address still waiting for data
  task automatic send_resp(input logic [`ORDR_ADDR_W-1:0] addr,
                           input logic [`ORDR_DATA_W-1:0] data);
    int owner;
    owner = -1;
    for (int i = 0; i < exp_addr.size(); i++) begin
      if (owner < 0 && !exp_has[i] && exp_addr[i] == addr) begin
        owner = i;
      end
    end
    if (owner >= 0) begin
      exp_data[owner] = data;
      exp_has[owner]  = 1'b1;
    end
    i_resp_valid = 1'b1;
    resp_unm_exp = (owner < 0);
    {i_resp_ch, i_resp_bk, i_resp_row, i_resp_col} = addr;
    i_resp_data  = data;
    @(posedge clk);
    #1;
    i_resp_valid = 1'b0;
    resp_unm_exp = 1'b0;
  endtask

  task automatic issue_batch(input int n, input logic typed);
    int t;
    for (int i = 0; i < n; i++) begin
      t        = typed ? i % 4 : 0;
      addrs[i] = random_addr(i);
      send_req(req_types[t], rd_classes[t], addrs[i]);
    end
  endtask

  task automatic respond_shuffled(input int n);
    int j;
    int tmp;
    for (int i = 0; i < n; i++) begin
      order[i] = i;
    end
    for (int i = n - 1; i > 0; i--) begin
      j        = int'(rand_bits(5) % (i + 1));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < n; i++) begin
      send_resp(addrs[order[i]], rand_bits(`ORDR_DATA_W));
    end
  endtask

  task automatic wait_drain();
    while (exp_addr.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_bit("o_req_rdy", o_req_rdy, 1'b1);
    check_bit("o_axi_valid", o_axi_valid, 1'b0);
    check_bit("o_pgen_valid", o_pgen_valid, 1'b0);
    check_bit("o_unmatched", o_unmatched, 1'b0);
    @(posedge clk);
    #1;
  endtask

  task automatic test_in_order();
    issue_batch(`ORDR_DEPTH, 1'b0);
    respond_shuffled(`ORDR_DEPTH);
    wait_drain();
  endtask

  // all four request types drained with random ready on both ports
  task automatic test_routing();
    issue_batch(12, 1'b1);
    respond_shuffled(12);
    while (exp_addr.size() != 0) begin
      i_axi_rdy  = (rand_bits(1) != 0);
      i_pgen_rdy = (rand_bits(1) != 0);
      @(posedge clk);
      #1;
    end
    i_axi_rdy  = 1'b1;
    i_pgen_rdy = 1'b1;
  endtask

  task automatic test_equal_addr();
    logic [`ORDR_ADDR_W-1:0] a;
    logic [`ORDR_ADDR_W-1:0] b;
    a = random_addr(0);
    b = random_addr(1);
    send_req(REQ_READ, DRAM_RD, a);
    send_req(REQ_READ_SBK, DRAMSBK_RD, b);
    send_req(REQ_READ_MAC, MACREG_RD, a);
    send_req(REQ_READ_AF, AFREG_RD, a);
    send_req(REQ_READ, DRAM_RD, b);
    send_req(REQ_READ_SBK, DRAMSBK_RD, a);
    // back to back responses put two equal addresses in flight together
    send_resp(a, rand_bits(`ORDR_DATA_W));
    send_resp(a, rand_bits(`ORDR_DATA_W));
    send_resp(b, rand_bits(`ORDR_DATA_W));
    send_resp(a, rand_bits(`ORDR_DATA_W));
    send_resp(a, rand_bits(`ORDR_DATA_W));
    send_resp(b, rand_bits(`ORDR_DATA_W));
    wait_drain();
  endtask

  task automatic test_full_backpressure();
    i_axi_rdy = 1'b0;
    issue_batch(`ORDR_DEPTH, 1'b0);
    @(negedge clk);
    check_bit("o_req_rdy", o_req_rdy, 1'b0);
    @(posedge clk);
    #1;
    respond_shuffled(`ORDR_DEPTH);
    while (!o_axi_valid) begin
      @(posedge clk);
      #1;
    end
    // monitor checks valid and data stay put meanwhile
    repeat (8) @(posedge clk);
    #1;
    // oldest entry still waiting at the port
    check_bit("o_axi_valid", o_axi_valid, 1'b1);
    check_data("o_axi_data", o_axi_data, exp_data[0]);
    i_axi_rdy = 1'b1;
    wait_drain();
    @(negedge clk);
    check_bit("o_req_rdy", o_req_rdy, 1'b1);
    @(posedge clk);
    #1;
  endtask

  task automatic test_unmatched();
    logic [`ORDR_ADDR_W-1:0] a;
    a = random_addr(2);
    send_resp(random_addr(3), rand_bits(`ORDR_DATA_W));
    send_req(REQ_READ_MAC, MACREG_RD, a);
    send_resp(random_addr(4), rand_bits(`ORDR_DATA_W));
    repeat (4) begin
      @(posedge clk);
      #1;
      check_bit("o_pgen_valid", o_pgen_valid, 1'b0);
    end
    send_resp(a, rand_bits(`ORDR_DATA_W));
    wait_drain();
  endtask

  task automatic take_release(input logic on_axi, input logic [`ORDR_DATA_W-1:0] data,
                              input rd_type_e rtype);
    if (exp_addr.size() == 0) begin
      report_error("an entry left with no outstanding request");
    end else if (!exp_has[0]) begin
      report_error("the oldest entry left before its response was sent");
    end else begin
      check_bit("routed to axi port", on_axi, exp_cls[0] == DRAM_RD);
      check_data(on_axi ? "o_axi_data" : "o_pgen_data", data, exp_data[0]);
      if (!on_axi) begin
        check_rd_type("o_pgen_rd_type", rtype, exp_cls[0]);
      end
      void'(exp_addr.pop_front());
      void'(exp_cls.pop_front());
      void'(exp_data.pop_front());
      void'(exp_has.pop_front());
    end
  endtask

  // expected unmatched flag lines up with the registered response
  always @(posedge clk or posedge rst) begin
    if (rst) begin
      unm_stage <= 1'b0;
    end else begin
      unm_stage <= i_resp_valid && resp_unm_exp;
    end
  end

  // output monitor sampling mid cycle when everything is settled
  always @(negedge clk) begin
    if (rst) begin
      held_axi  = 1'b0;
      held_pgen = 1'b0;
    end else begin
      check_bit("o_unmatched", o_unmatched, unm_stage);
      if (o_axi_valid && o_pgen_valid) begin
        report_error("both output ports are valid in the same cycle");
      end
      if (held_axi) begin
        check_bit("o_axi_valid", o_axi_valid, 1'b1);
        check_data("o_axi_data", o_axi_data, held_data);
      end
      if (held_pgen) begin
        check_bit("o_pgen_valid", o_pgen_valid, 1'b1);
        check_data("o_pgen_data", o_pgen_data, held_data);
      end
      held_axi  = o_axi_valid && !i_axi_rdy;
      held_pgen = o_pgen_valid && !i_pgen_rdy;
      held_data = o_axi_valid ? o_axi_data : o_pgen_data;
      if (o_axi_valid && i_axi_rdy) begin
        take_release(1'b1, o_axi_data, DRAM_RD);
      end
      if (o_pgen_valid && i_pgen_rdy) begin
        take_release(1'b0, o_pgen_data, o_pgen_rd_type);
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    i_req_valid  = 1'b0;
    i_req_type   = REQ_READ;
    {i_req_ch, i_req_bk, i_req_row, i_req_col} = '0;
    i_resp_valid = 1'b0;
    {i_resp_ch, i_resp_bk, i_resp_row, i_resp_col} = '0;
    i_resp_data  = '0;
    i_axi_rdy    = 1'b1;
    i_pgen_rdy   = 1'b1;
    resp_unm_exp = 1'b0;
    @(negedge rst);
    @(posedge clk);
    #1;
    test_reset_state();
    test_in_order();
    test_routing();
    test_equal_addr();
    test_full_backpressure();
    test_unmatched();
    // idle cycles so a stray release would still be caught
    repeat (4) @(posedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst
);

  // 4 ns period
  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;
  end

  // reset held over three rising edges
  initial begin
    o_rst = 1'b1;
    repeat (3) @(posedge o_clk);
    #1 o_rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: ordr_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ordr_config.svh"

module ordr_top
  import ordr_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    rst,
  // read requests from the packet generator
  input  wire logic                    i_req_valid,
  output logic                         o_req_rdy,
  input  req_type_e                    i_req_type,
  input  wire logic [`ORDR_CH_W-1:0]   i_req_ch,
  input  wire logic [`ORDR_BK_W-1:0]   i_req_bk,
  input  wire logic [`ORDR_ROW_W-1:0]  i_req_row,
  input  wire logic [`ORDR_COL_W-1:0]  i_req_col,
  // out of order read responses
  input  wire logic                    i_resp_valid,
  input  wire logic [`ORDR_CH_W-1:0]   i_resp_ch,
  input  wire logic [`ORDR_BK_W-1:0]   i_resp_bk,
  input  wire logic [`ORDR_ROW_W-1:0]  i_resp_row,
  input  wire logic [`ORDR_COL_W-1:0]  i_resp_col,
  input  wire logic [`ORDR_DATA_W-1:0] i_resp_data,
  // axi bridge
  output logic                         o_axi_valid,
  input  wire logic                    i_axi_rdy,
  output logic [`ORDR_DATA_W-1:0]      o_axi_data,
  // back to the packet generator
  output logic                         o_pgen_valid,
  input  wire logic                    i_pgen_rdy,
  output logic [`ORDR_DATA_W-1:0]      o_pgen_data,
  output rd_type_e                     o_pgen_rd_type,
  output logic                         o_unmatched
);

  logic [`ORDR_DEPTH*`ORDR_ADDR_W-1:0] tags;
  rd_type_e [`ORDR_DEPTH-1:0]          types;
  logic [`ORDR_DEPTH-1:0]              pending;
  logic [`ORDR_DEPTH-1:0]              filled;
  logic [`ORDR_IDX_W-1:0]              oldest_idx;
  logic                                match_valid;
  logic [`ORDR_IDX_W-1:0]              match_idx;
  logic [`ORDR_DATA_W-1:0]             match_data;
  logic                                pop;

  ordr_tag_store u_tag_store (
    .clk          (clk),
    .rst          (rst),
    .i_req_valid  (i_req_valid),
    .o_req_rdy    (o_req_rdy),
    .i_req_type   (i_req_type),
    .i_req_ch     (i_req_ch),
    .i_req_bk     (i_req_bk),
    .i_req_row    (i_req_row),
    .i_req_col    (i_req_col),
    .i_pop        (pop),
    .o_tags       (tags),
    .o_types      (types),
    .o_pending    (pending),
    .o_oldest_idx (oldest_idx)
  );

  ordr_resp_match u_resp_match (
    .clk           (clk),
    .rst           (rst),
    .i_resp_valid  (i_resp_valid),
    .i_resp_ch     (i_resp_ch),
    .i_resp_bk     (i_resp_bk),
    .i_resp_row    (i_resp_row),
    .i_resp_col    (i_resp_col),
    .i_resp_data   (i_resp_data),
    .i_tags        (tags),
    .i_pending     (pending),
    .i_filled      (filled),
    .i_oldest_idx  (oldest_idx),
    .o_match_valid (match_valid),
    .o_match_idx   (match_idx),
    .o_match_data  (match_data),
    .o_unmatched   (o_unmatched)
  );

  ordr_release u_release (
    .clk            (clk),
    .rst            (rst),
    .i_match_valid  (match_valid),
    .i_match_idx    (match_idx),
    .i_match_data   (match_data),
    .i_types        (types),
    .i_oldest_idx   (oldest_idx),
    .o_filled       (filled),
    .o_pop          (pop),
    .o_axi_valid    (o_axi_valid),
    .i_axi_rdy      (i_axi_rdy),
    .o_axi_data     (o_axi_data),
    .o_pgen_valid   (o_pgen_valid),
    .i_pgen_rdy     (i_pgen_rdy),
    .o_pgen_data    (o_pgen_data),
    .o_pgen_rd_type (o_pgen_rd_type)
  );

endmodule

`default_nettype wire

// File: ordr_release.sv
`timescale 1ns/1ps
`default_nettype none

`include "ordr_config.svh"

module ordr_release
  import ordr_pkg::*;
(
  input  wire logic                                  clk,
  input  wire logic                                  rst,
  // match result
  input  wire logic                                  i_match_valid,
  input  wire logic [`ORDR_IDX_W-1:0]                i_match_idx,
  input  wire logic [`ORDR_DATA_W-1:0]               i_match_data,
  // slot state from the tag store
  input  rd_type_e [`ORDR_DEPTH-1:0]                 i_types,
  input  wire logic [`ORDR_IDX_W-1:0]                i_oldest_idx,
  output logic [`ORDR_DEPTH-1:0]                     o_filled,
  output logic                                       o_pop,
  // axi bridge port
  output logic                                       o_axi_valid,
  input  wire logic                                  i_axi_rdy,
  output logic [`ORDR_DATA_W-1:0]                    o_axi_data,
  // packet generator return port
  output logic                                       o_pgen_valid,
  input  wire logic                                  i_pgen_rdy,
  output logic [`ORDR_DATA_W-1:0]                    o_pgen_data,
  output rd_type_e                                   o_pgen_rd_type
);

  logic [`ORDR_DATA_W-1:0]   data_mem [`ORDR_DEPTH];
  logic [`ORDR_DEPTH-1:0]    filled_q;
  logic                      fill_valid_q;
  logic [`ORDR_IDX_W-1:0]    fill_idx_q;
  logic                      out_valid_q;
  logic                      out_axi_q;
  logic [`ORDR_DATA_W-1:0]   out_data_q;
  rd_type_e                  out_type_q;
  logic                      load;
  logic [`ORDR_IDX_W-1:0]    next_idx;

  // handshake on whichever port currently holds the oldest entry
  assign o_pop = (o_axi_valid && i_axi_rdy) || (o_pgen_valid && i_pgen_rdy);

  // output stage reloads when empty or when its entry leaves
  assign load     = !out_valid_q || o_pop;
  assign next_idx = o_pop ? i_oldest_idx + 1'b1 : i_oldest_idx;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      filled_q     <= '0;
      fill_valid_q <= 1'b0;
      out_valid_q  <= 1'b0;
      out_axi_q    <= 1'b0;
    end else begin
      fill_valid_q <= i_match_valid;
      // filled flag trails the data write by one cycle
      if (fill_valid_q) begin
        filled_q[fill_idx_q] <= 1'b1;
      end
      if (o_pop) begin
        filled_q[i_oldest_idx] <= 1'b0;
      end
      if (load) begin
        out_valid_q <= filled_q[next_idx];
        out_axi_q   <= (i_types[next_idx] == DRAM_RD);
      end
    end
  end

  // payload side
  always_ff @(posedge clk) begin
    if (i_match_valid) begin
      data_mem[i_match_idx] <= i_match_data;
    end
    fill_idx_q <= i_match_idx;
    if (load) begin
      out_data_q <= data_mem[next_idx];
      out_type_q <= i_types[next_idx];
    end
  end

  assign o_filled       = filled_q;
  assign o_axi_valid    = out_valid_q && out_axi_q;
  assign o_axi_data     = out_data_q;
  assign o_pgen_valid   = out_valid_q && !out_axi_q;
  assign o_pgen_data    = out_data_q;
  assign o_pgen_rd_type = out_type_q;

  // matcher must never pick a slot that is filled or whose fill is in flight
  a_no_double_fill: assert property (
    @(posedge clk) disable iff (rst)
    i_match_valid |-> (!filled_q[i_match_idx] &&
                       !(fill_valid_q && fill_idx_q == i_match_idx))
  ) else $error("match into filled slot %0d", i_match_idx);

endmodule

`default_nettype wire

// File: ordr_resp_match.sv
`timescale 1ns/1ps
`default_nettype none

`include "ordr_config.svh"

module ordr_resp_match
  import ordr_pkg::*;
(
  input  wire logic                                  clk,
  input  wire logic                                  rst,
  // response channel, always accepted
  input  wire logic                                  i_resp_valid,
  input  wire logic [`ORDR_CH_W-1:0]                 i_resp_ch,
  input  wire logic [`ORDR_BK_W-1:0]                 i_resp_bk,
  input  wire logic [`ORDR_ROW_W-1:0]                i_resp_row,
  input  wire logic [`ORDR_COL_W-1:0]                i_resp_col,
  input  wire logic [`ORDR_DATA_W-1:0]               i_resp_data,
  // slot state
  input  wire logic [`ORDR_DEPTH*`ORDR_ADDR_W-1:0]   i_tags,
  input  wire logic [`ORDR_DEPTH-1:0]                i_pending,
  input  wire logic [`ORDR_DEPTH-1:0]                i_filled,
  input  wire logic [`ORDR_IDX_W-1:0]                i_oldest_idx,
  // match result towards release
  output logic                                       o_match_valid,
  output logic [`ORDR_IDX_W-1:0]                     o_match_idx,
  output logic [`ORDR_DATA_W-1:0]                    o_match_data,
  output logic                                       o_unmatched
);

  logic                          resp_valid_q;
  logic [`ORDR_ADDR_W-1:0]       resp_addr_q;
  logic [`ORDR_DATA_W-1:0]       resp_data_q;
  logic                          last_valid_q;
  logic [`ORDR_IDX_W-1:0]        last_idx_q;
  logic [`ORDR_DEPTH-1:0]        cand;
  logic                          hit;
  logic [`ORDR_IDX_W-1:0]        hit_idx;

  // single response stage
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      resp_valid_q <= 1'b0;
      last_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= i_resp_valid;
      last_valid_q <= o_match_valid;
    end
  end

  always_ff @(posedge clk) begin
    resp_addr_q <= {i_resp_ch, i_resp_bk, i_resp_row, i_resp_col};
    resp_data_q <= i_resp_data;
    last_idx_q  <= hit_idx;
  end

  // slots that could take this response
  // the slot matched one cycle ago is not yet flagged filled, so skip it
  always_comb begin
    for (int i = 0; i < `ORDR_DEPTH; i++) begin
      cand[i] = i_pending[i] && !i_filled[i] &&
                (i_tags[i*`ORDR_ADDR_W +: `ORDR_ADDR_W] == resp_addr_q) &&
                !(last_valid_q && last_idx_q == `ORDR_IDX_W'(i));
    end
  end

  // first candidate scanning upward from the oldest slot, with wrap
  always_comb begin
    logic [`ORDR_IDX_W-1:0] scan_idx;
    hit     = 1'b0;
    hit_idx = '0;
    for (int k = 0; k < `ORDR_DEPTH; k++) begin
      scan_idx = i_oldest_idx + `ORDR_IDX_W'(k);
      if (!hit && cand[scan_idx]) begin
        hit     = 1'b1;
        hit_idx = scan_idx;
      end
    end
  end

  assign o_match_valid = resp_valid_q && hit;
  assign o_match_idx   = hit_idx;
  assign o_match_data  = resp_data_q;
  // no owner for this response, it gets dropped
  assign o_unmatched   = resp_valid_q && !hit;

endmodule

`default_nettype wire

// File: ordr_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "ordr_config.svh"

module ordr_tag_store
  import ordr_pkg::*;
(
  input  wire logic                                  clk,
  input  wire logic                                  rst,
  // request channel
  input  wire logic                                  i_req_valid,
  output logic                                       o_req_rdy,
  input  req_type_e                                  i_req_type,
  input  wire logic [`ORDR_CH_W-1:0]                 i_req_ch,
  input  wire logic [`ORDR_BK_W-1:0]                 i_req_bk,
  input  wire logic [`ORDR_ROW_W-1:0]                i_req_row,
  input  wire logic [`ORDR_COL_W-1:0]                i_req_col,
  // oldest entry has left
  input  wire logic                                  i_pop,
  // slot state towards matcher and release
  output logic [`ORDR_DEPTH*`ORDR_ADDR_W-1:0]        o_tags,
  output rd_type_e [`ORDR_DEPTH-1:0]                 o_types,
  output logic [`ORDR_DEPTH-1:0]                     o_pending,
  output logic [`ORDR_IDX_W-1:0]                     o_oldest_idx
);

  logic [`ORDR_IDX_W-1:0]             empty_ptr;
  logic [`ORDR_IDX_W-1:0]             oldest_ptr;
  logic [`ORDR_CNT_W-1:0]             count;
  logic [`ORDR_DEPTH-1:0]             pending_q;
  logic [`ORDR_DEPTH*`ORDR_ADDR_W-1:0] tags_q;
  rd_type_e [`ORDR_DEPTH-1:0]          types_q;
  logic                                push;

  // room left as long as not every slot is taken
  assign o_req_rdy = (count < `ORDR_DEPTH);
  assign push      = i_req_valid && o_req_rdy;

  // pointers, occupancy and per slot pending bits
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      empty_ptr  <= '0;
      oldest_ptr <= '0;
      count      <= '0;
      pending_q  <= '0;
    end else begin
      if (push) begin
        empty_ptr            <= empty_ptr + 1'b1;
        pending_q[empty_ptr] <= 1'b1;
      end
      if (i_pop) begin
        oldest_ptr            <= oldest_ptr + 1'b1;
        pending_q[oldest_ptr] <= 1'b0;
      end
      case ({push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // tag and class payload written at the empty slot
  always_ff @(posedge clk) begin
    if (push) begin
      tags_q[empty_ptr*`ORDR_ADDR_W +: `ORDR_ADDR_W] <= {i_req_ch, i_req_bk,
                                                        i_req_row, i_req_col};
      types_q[empty_ptr] <= to_rd_type(i_req_type);
    end
  end

  assign o_tags       = tags_q;
  assign o_types      = types_q;
  assign o_pending    = pending_q;
  assign o_oldest_idx = oldest_ptr;

  // the slot under the empty pointer must really be free when written
  // a set pending bit there means the pointers have drifted apart
  a_push_free_slot: assert property (
    @(posedge clk) disable iff (rst)
    push |-> !pending_q[empty_ptr]
  ) else $error("push into occupied slot %0d", empty_ptr);

  // release may only pop a live entry at the oldest position
  a_pop_not_empty: assert property (
    @(posedge clk) disable iff (rst)
    i_pop |-> (count != '0 && pending_q[oldest_ptr])
  ) else $error("pop with empty store");

endmodule

`default_nettype wire

// File: ordr_pkg.sv
`default_nettype none

package ordr_pkg;

  // opcode carried by an incoming read request
  typedef enum logic [1:0] {
    REQ_READ     = 2'd0,
    REQ_READ_SBK = 2'd1,
    REQ_READ_MAC = 2'd2,
    REQ_READ_AF  = 2'd3
  } req_type_e;

  // class kept with each slot, selects the output port on release
  typedef enum logic [1:0] {
    DRAM_RD    = 2'd0,
    DRAMSBK_RD = 2'd1,
    MACREG_RD  = 2'd2,
    AFREG_RD   = 2'd3
  } rd_type_e;

  // one to one mapping from request opcode to read class
  function automatic rd_type_e to_rd_type(input req_type_e req);
    case (req)
      REQ_READ:     return DRAM_RD;
      REQ_READ_SBK: return DRAMSBK_RD;
      REQ_READ_MAC: return MACREG_RD;
      REQ_READ_AF:  return AFREG_RD;
      default:      return DRAM_RD;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: ordr_config.svh
`ifndef ORDR_CONFIG_SVH
`define ORDR_CONFIG_SVH

// number of reads that can be outstanding at once
`define ORDR_DEPTH 16

// slot index, must cover ORDR_DEPTH exactly
`define ORDR_IDX_W 4

// dram address fields
`define ORDR_CH_W 4
`define ORDR_BK_W 4
`define ORDR_ROW_W 14
`define ORDR_COL_W 6

// full address as stored per slot, ordered {ch, bk, row, col}
`define ORDR_ADDR_W (`ORDR_CH_W + `ORDR_BK_W + `ORDR_ROW_W + `ORDR_COL_W)

// read response payload
`define ORDR_DATA_W 32

// occupancy count, one bit wider than the index so a full store is visible
`define ORDR_CNT_W (`ORDR_IDX_W + 1)

`endif
